// ==== verilog/raw_rgb_pkg.sv ====
package raw_rgb_pkg;

    localparam int DATA_WIDTH   = 10;
    localparam int X_WIDTH      = 13;
    localparam int Y_WIDTH      = 12;
    localparam int MAX_COLS     = 256;   // longest line the demosaic can hold

    localparam int WB_ADR_WIDTH = 8;
    localparam int WB_DAT_WIDTH = 32;

    localparam int COEFF_WIDTH  = 18;
    localparam int COEFF_FRAC   = 8;

    // enabled cycles from stream input acceptance to output valid
    localparam int PIPE_LATENCY = 6;

    typedef logic [DATA_WIDTH-1:0] raw_t;

    typedef struct packed {
        raw_t r;
        raw_t g;
        raw_t b;
    } rgb_t;

    // same layout as the output tdata word
    typedef struct packed {
        raw_t raw;
        rgb_t rgb;
    } pixel_t;

    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;
    typedef coeff_t [0:8] coeff_mat_t;   // row-major with row 0 making r

    // color of pixel (0,0) is 0 RGGB, 1 GRBG, 2 GBRG or 3 BGGR
    typedef logic [1:0] bayer_phase_t;

    typedef logic [WB_DAT_WIDTH-1:0] wb_data_t;

    localparam logic [WB_ADR_WIDTH-1:0] REG_PHASE      = 8'h00;
    localparam logic [WB_ADR_WIDTH-1:0] REG_COEFF_BASE = 8'h10;

    localparam coeff_t     COEFF_ONE      = coeff_t'(1 << COEFF_FRAC);
    localparam coeff_mat_t COEFF_IDENTITY = '{COEFF_ONE, '0, '0,
                                              '0, COEFF_ONE, '0,
                                              '0, '0, COEFF_ONE};

endpackage

// ==== verilog/img_if.sv ====
interface img_if #(
    parameter type data_t = logic
) ();

    logic  row_first;
    logic  row_last;
    logic  col_first;
    logic  col_last;
    logic  de;
    logic  user;
    data_t data;
    logic  valid;

    modport src (
        output row_first, row_last, col_first, col_last,
        output de, user, data, valid
    );

    modport sink (
        input  row_first, row_last, col_first, col_last,
        input  de, user, data, valid
    );

endinterface

// ==== verilog/axi4s_img_bridge.sv ====
module axi4s_img_bridge (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    input  logic [raw_rgb_pkg::X_WIDTH-1:0] param_width_i,
    input  logic [raw_rgb_pkg::Y_WIDTH-1:0] param_height_i,
    input  raw_rgb_pkg::raw_t               s_tdata_i,
    input  logic                            s_tuser_i,
    input  logic                            s_tvalid_i,
    output logic                            s_tready_o,
    output raw_rgb_pkg::pixel_t             m_tdata_o,
    output logic                            m_tuser_o,
    output logic                            m_tlast_o,
    output logic                            m_tvalid_o,
    input  logic                            m_tready_i,
    output logic                            cke_o,
    output logic                            frame_start_o,
    img_if.src                              img_src,
    img_if.sink                             img_sink
);

    logic [raw_rgb_pkg::X_WIDTH-1:0] x_cnt;
    logic [raw_rgb_pkg::Y_WIDTH-1:0] y_cnt;
    logic [raw_rgb_pkg::X_WIDTH-1:0] cur_x;
    logic [raw_rgb_pkg::Y_WIDTH-1:0] cur_y;
    logic                            accept;

    // the whole pipeline moves only while the output register can take a word
    assign cke_o         = !m_tvalid_o || m_tready_i;
    assign s_tready_o    = cke_o;
    assign accept        = s_tvalid_i && cke_o;
    assign frame_start_o = accept && s_tuser_i;

    // tuser restarts the frame at the pixel that carries it
    assign cur_x = s_tuser_i ? '0 : x_cnt;
    assign cur_y = s_tuser_i ? '0 : y_cnt;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            x_cnt         <= '0;
            y_cnt         <= '0;
            img_src.valid <= 1'b0;
            img_src.de    <= 1'b0;
            m_tvalid_o    <= 1'b0;
        end else if (cke_o) begin
            img_src.valid <= s_tvalid_i;
            img_src.de    <= s_tvalid_i;
            m_tvalid_o    <= img_sink.valid && img_sink.de;
            if (accept) begin
                if (cur_x == param_width_i - 1'b1) begin
                    x_cnt <= '0;
                    y_cnt <= (cur_y == param_height_i - 1'b1) ? '0 : cur_y + 1'b1;
                end else begin
                    x_cnt <= cur_x + 1'b1;
                    y_cnt <= cur_y;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cke_o) begin
            img_src.data      <= s_tdata_i;
            img_src.user      <= s_tuser_i;
            img_src.row_first <= (cur_y == '0);
            img_src.row_last  <= (cur_y == param_height_i - 1'b1);
            img_src.col_first <= (cur_x == '0);
            img_src.col_last  <= (cur_x == param_width_i - 1'b1);
            m_tdata_o         <= img_sink.data;
            m_tlast_o         <= img_sink.col_last;   // tlast rebuilt from the column count
            m_tuser_o         <= img_sink.user;
        end
    end

endmodule

// ==== verilog/img_demosaic_2x2.sv ====
module img_demosaic_2x2 (
    input  logic                      aclk,
    input  logic                      rst_n_i,
    input  logic                      cke_i,
    input  raw_rgb_pkg::bayer_phase_t phase_i,
    img_if.sink                       img_in,
    img_if.src                        img_out
);

    localparam int ADDR_WIDTH = $clog2(raw_rgb_pkg::MAX_COLS);

    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
        logic de;
        logic user;
    } side_t;

    raw_rgb_pkg::raw_t         line_mem [raw_rgb_pkg::MAX_COLS];
    logic [ADDR_WIDTH-1:0]     x_cnt;
    logic [ADDR_WIDTH-1:0]     cur_x;
    logic                      y_odd;
    logic                      cur_y_odd;
    raw_rgb_pkg::raw_t         prev_cur_q;   // column x-1 of this row
    raw_rgb_pkg::raw_t         prev_up_q;    // column x-1 of the row above after clamping
    raw_rgb_pkg::raw_t         w_u;
    raw_rgb_pkg::raw_t         w_l;
    raw_rgb_pkg::raw_t         w_ul;
    raw_rgb_pkg::raw_t         ul_q;
    raw_rgb_pkg::raw_t         u_q;
    raw_rgb_pkg::raw_t         l_q;
    raw_rgb_pkg::raw_t         c_q;
    logic                      px_q;
    logic                      py_q;
    side_t                     side_q;
    logic                      v1_q;
    raw_rgb_pkg::raw_t         r;
    raw_rgb_pkg::raw_t         b;
    logic [raw_rgb_pkg::DATA_WIDTH:0] g_sum;

    assign cur_x     = img_in.col_first ? '0 : x_cnt;
    assign cur_y_odd = img_in.row_first ? 1'b0 : (img_in.col_first ? !y_odd : y_odd);

    // neighbors outside the frame are clamped to row 0 and column 0
    assign w_u  = img_in.row_first ? img_in.data : line_mem[cur_x];
    assign w_l  = img_in.col_first ? img_in.data : prev_cur_q;
    assign w_ul = img_in.col_first ? w_u : prev_up_q;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            x_cnt         <= '0;
            y_odd         <= 1'b0;
            v1_q          <= 1'b0;
            img_out.valid <= 1'b0;
        end else if (cke_i) begin
            v1_q          <= img_in.valid;
            img_out.valid <= v1_q;
            if (img_in.valid) begin
                x_cnt <= cur_x + 1'b1;
                y_odd <= cur_y_odd;
            end
        end
    end

    // effective parity 00 is R and 11 is B; the window always holds one of each
    always_comb begin
        case ({py_q, px_q})
            2'b00: begin
                r     = c_q;
                b     = ul_q;
                g_sum = u_q + l_q;
            end
            2'b11: begin
                r     = ul_q;
                b     = c_q;
                g_sum = u_q + l_q;
            end
            2'b01: begin
                r     = l_q;
                b     = u_q;
                g_sum = c_q + ul_q;
            end
            default: begin
                r     = u_q;
                b     = l_q;
                g_sum = c_q + ul_q;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (cke_i) begin
            if (img_in.valid) begin
                line_mem[cur_x] <= img_in.data;
                prev_cur_q      <= img_in.data;
                prev_up_q       <= w_u;
            end
            ul_q   <= w_ul;
            u_q    <= w_u;
            l_q    <= w_l;
            c_q    <= img_in.data;
            px_q   <= cur_x[0] ^ phase_i[0];
            py_q   <= cur_y_odd ^ phase_i[1];   // phase sampled once per pixel here
            side_q <= '{img_in.row_first, img_in.row_last, img_in.col_first,
                        img_in.col_last, img_in.de, img_in.user};

            img_out.data      <= {c_q, r, g_sum[raw_rgb_pkg::DATA_WIDTH:1], b};
            img_out.row_first <= side_q.row_first;
            img_out.row_last  <= side_q.row_last;
            img_out.col_first <= side_q.col_first;
            img_out.col_last  <= side_q.col_last;
            img_out.de        <= side_q.de;
            img_out.user      <= side_q.user;
        end
    end

endmodule

// ==== verilog/img_color_matrix.sv ====
module img_color_matrix (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic                    cke_i,
    input  raw_rgb_pkg::coeff_mat_t coeff_i,
    img_if.sink                     img_in,
    img_if.src                      img_out
);

    localparam int PROD_WIDTH = raw_rgb_pkg::COEFF_WIDTH + raw_rgb_pkg::DATA_WIDTH + 1;
    localparam int SUM_WIDTH  = PROD_WIDTH + 2;
    localparam int PIX_MAX    = (1 << raw_rgb_pkg::DATA_WIDTH) - 1;

    typedef struct packed {
        logic              row_first;
        logic              row_last;
        logic              col_first;
        logic              col_last;
        logic              de;
        logic              user;
        raw_rgb_pkg::raw_t raw;
    } side_t;

    raw_rgb_pkg::coeff_mat_t                coeff_q;
    raw_rgb_pkg::coeff_mat_t                coeff_use;
    logic signed [raw_rgb_pkg::DATA_WIDTH:0] color [3];
    logic signed [PROD_WIDTH-1:0]           prod_q [9];
    logic signed [SUM_WIDTH-1:0]            sum_q [3];
    logic signed [SUM_WIDTH-1:0]            shifted [3];
    raw_rgb_pkg::raw_t                      clip [3];
    side_t                                  side_q [2];
    logic [1:0]                             vld_q;

    // the first pixel of a frame picks up the new matrix
    // pixels still in flight keep the matrix of their own frame
    assign coeff_use = (img_in.valid && img_in.user) ? coeff_i : coeff_q;

    assign color[0] = $signed({1'b0, img_in.data.rgb.r});
    assign color[1] = $signed({1'b0, img_in.data.rgb.g});
    assign color[2] = $signed({1'b0, img_in.data.rgb.b});

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            shifted[i] = sum_q[i] >>> raw_rgb_pkg::COEFF_FRAC;   // floor toward minus infinity
            if (shifted[i] < 0) begin
                clip[i] = '0;
            end else if (shifted[i] > PIX_MAX) begin
                clip[i] = '1;
            end else begin
                clip[i] = shifted[i][raw_rgb_pkg::DATA_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            vld_q         <= '0;
            img_out.valid <= 1'b0;
            coeff_q       <= raw_rgb_pkg::COEFF_IDENTITY;
        end else if (cke_i) begin
            vld_q         <= {vld_q[0], img_in.valid};
            img_out.valid <= vld_q[1];
            coeff_q       <= coeff_use;
        end
    end

    always_ff @(posedge aclk) begin
        if (cke_i) begin
            for (int i = 0; i < 9; i++) begin
                prod_q[i] <= $signed(coeff_use[i]) * color[i % 3];
            end
            for (int row = 0; row < 3; row++) begin
                sum_q[row] <= prod_q[3*row] + prod_q[3*row+1] + prod_q[3*row+2];
            end
            side_q[0] <= '{img_in.row_first, img_in.row_last, img_in.col_first,
                           img_in.col_last, img_in.de, img_in.user, img_in.data.raw};
            side_q[1] <= side_q[0];

            img_out.data      <= {side_q[1].raw, clip[0], clip[1], clip[2]};
            img_out.row_first <= side_q[1].row_first;
            img_out.row_last  <= side_q[1].row_last;
            img_out.col_first <= side_q[1].col_first;
            img_out.col_last  <= side_q[1].col_last;
            img_out.de        <= side_q[1].de;
            img_out.user      <= side_q[1].user;
        end
    end

endmodule

// ==== verilog/img_param_regs.sv ====
module img_param_regs (
    input  logic                                 aclk,
    input  logic                                 rst_n_i,
    input  logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  raw_rgb_pkg::wb_data_t                s_wb_dat_i,
    output raw_rgb_pkg::wb_data_t                s_wb_dat_o,
    input  logic                                 s_wb_we_i,
    input  logic                                 s_wb_stb_i,
    output logic                                 s_wb_ack_o,
    input  logic                                 update_req_i,
    input  logic                                 frame_start_i,
    output raw_rgb_pkg::bayer_phase_t            phase_o,
    output raw_rgb_pkg::coeff_mat_t              coeff_o
);

    logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] coeff_idx;
    logic                                 is_coeff;
    logic                                 wr_en;
    raw_rgb_pkg::bayer_phase_t            phase_sh;
    raw_rgb_pkg::coeff_mat_t              coeff_sh;

    assign coeff_idx = s_wb_adr_i - raw_rgb_pkg::REG_COEFF_BASE;
    assign is_coeff  = (coeff_idx < 9);   // addresses below the base wrap high
    assign wr_en     = s_wb_stb_i && !s_wb_ack_o && s_wb_we_i;

    always_comb begin
        s_wb_dat_o = '0;
        if (s_wb_adr_i == raw_rgb_pkg::REG_PHASE) begin
            s_wb_dat_o[1:0] = phase_sh;
        end else if (is_coeff) begin
            s_wb_dat_o = $signed(coeff_sh[coeff_idx]);   // sign extended to the bus width
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            s_wb_ack_o <= 1'b0;
            phase_sh   <= '0;
            coeff_sh   <= raw_rgb_pkg::COEFF_IDENTITY;
            phase_o    <= '0;
            coeff_o    <= raw_rgb_pkg::COEFF_IDENTITY;
        end else begin
            s_wb_ack_o <= s_wb_stb_i && !s_wb_ack_o;
            if (wr_en && s_wb_adr_i == raw_rgb_pkg::REG_PHASE) begin
                phase_sh <= s_wb_dat_i[1:0];
            end
            if (wr_en && is_coeff) begin
                coeff_sh[coeff_idx] <= s_wb_dat_i[raw_rgb_pkg::COEFF_WIDTH-1:0];
            end
            // shadow values go live only at a frame start with a pending request
            if (frame_start_i && update_req_i) begin
                phase_o <= phase_sh;
                coeff_o <= coeff_sh;
            end
        end
    end

endmodule

// ==== verilog/video_raw_to_rgb.sv ====
module video_raw_to_rgb (
    input  logic                                 aclk,
    input  logic                                 rst_n_i,
    input  logic                                 update_req_i,
    input  logic [raw_rgb_pkg::X_WIDTH-1:0]      param_width_i,
    input  logic [raw_rgb_pkg::Y_WIDTH-1:0]      param_height_i,
    input  raw_rgb_pkg::raw_t                    s_tdata_i,
    input  logic                                 s_tuser_i,
    input  logic                                 s_tvalid_i,
    output logic                                 s_tready_o,
    output raw_rgb_pkg::pixel_t                  m_tdata_o,
    output logic                                 m_tuser_o,
    output logic                                 m_tlast_o,
    output logic                                 m_tvalid_o,
    input  logic                                 m_tready_i,
    input  logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  raw_rgb_pkg::wb_data_t                s_wb_dat_i,
    output raw_rgb_pkg::wb_data_t                s_wb_dat_o,
    input  logic                                 s_wb_we_i,
    input  logic                                 s_wb_stb_i,
    output logic                                 s_wb_ack_o
);

    logic                      cke;
    logic                      frame_start;
    raw_rgb_pkg::bayer_phase_t phase;
    raw_rgb_pkg::coeff_mat_t   coeff;

    img_if #(.data_t(raw_rgb_pkg::raw_t))   img_raw ();
    img_if #(.data_t(raw_rgb_pkg::pixel_t)) img_dem ();
    img_if #(.data_t(raw_rgb_pkg::pixel_t)) img_mat ();

    axi4s_img_bridge u_bridge (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .param_width_i  (param_width_i),
        .param_height_i (param_height_i),
        .s_tdata_i      (s_tdata_i),
        .s_tuser_i      (s_tuser_i),
        .s_tvalid_i     (s_tvalid_i),
        .s_tready_o     (s_tready_o),
        .m_tdata_o      (m_tdata_o),
        .m_tuser_o      (m_tuser_o),
        .m_tlast_o      (m_tlast_o),
        .m_tvalid_o     (m_tvalid_o),
        .m_tready_i     (m_tready_i),
        .cke_o          (cke),
        .frame_start_o  (frame_start),
        .img_src        (img_raw.src),
        .img_sink       (img_mat.sink)
    );

    img_demosaic_2x2 u_demosaic (
        .aclk    (aclk),
        .rst_n_i (rst_n_i),
        .cke_i   (cke),
        .phase_i (phase),
        .img_in  (img_raw.sink),
        .img_out (img_dem.src)
    );

    img_color_matrix u_matrix (
        .aclk    (aclk),
        .rst_n_i (rst_n_i),
        .cke_i   (cke),
        .coeff_i (coeff),
        .img_in  (img_dem.sink),
        .img_out (img_mat.src)
    );

    img_param_regs u_regs (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .s_wb_adr_i    (s_wb_adr_i),
        .s_wb_dat_i    (s_wb_dat_i),
        .s_wb_dat_o    (s_wb_dat_o),
        .s_wb_we_i     (s_wb_we_i),
        .s_wb_stb_i    (s_wb_stb_i),
        .s_wb_ack_o    (s_wb_ack_o),
        .update_req_i  (update_req_i),
        .frame_start_i (frame_start),
        .phase_o       (phase),
        .coeff_o       (coeff)
    );

endmodule

// ==== verification/video_raw_to_rgb_sva.sv ====
module video_raw_to_rgb_sva (
    input logic                aclk,
    input logic                rst_n_i,
    input logic                m_tvalid_o,
    input logic                m_tready_i,
    input raw_rgb_pkg::pixel_t m_tdata_o,
    input logic                s_wb_stb_i,
    input logic                s_wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output word stays put until the sink takes it
    property stream_hold_p;
        @(posedge aclk) disable iff (!rst_n_i)
            (m_tvalid_o && !m_tready_i) |=> (m_tvalid_o && $stable(m_tdata_o));
    endproperty

    property ack_after_stb_p;
        @(posedge aclk) disable iff (!rst_n_i)
            $rose(s_wb_ack_o) |-> $past(s_wb_stb_i && !s_wb_ack_o);
    endproperty

    property valid_low_in_reset_p;
        @(posedge aclk) !rst_n_i |=> !m_tvalid_o;
    endproperty

    assert property (stream_hold_p) else $error("output stream changed while stalled");
    assert property (ack_after_stb_p) else $error("wishbone ack without a preceding strobe");
    assert property (valid_low_in_reset_p) else $error("output valid high during reset");

endmodule

bind video_raw_to_rgb video_raw_to_rgb_sva u_sva (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tdata_o  (m_tdata_o),
    .s_wb_stb_i (s_wb_stb_i),
    .s_wb_ack_o (s_wb_ack_o)
);

// ==== verification/tb_video_raw_to_rgb.sv ====
module tb_video_raw_to_rgb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_W        = 8;
    localparam int FRAME_H        = 6;
    localparam int NUM_FRAMES     = 10;
    localparam int TIMEOUT_CYCLES = 4 * NUM_FRAMES * FRAME_W * FRAME_H + 500;
    localparam int PIX_MAX        = (1 << raw_rgb_pkg::DATA_WIDTH) - 1;

    typedef struct packed {
        raw_rgb_pkg::pixel_t px;
        logic                last;
        logic                user;
    } exp_t;

    logic                                 aclk;
    logic                                 rst_n_i;
    logic                                 update_req_i;
    logic [raw_rgb_pkg::X_WIDTH-1:0]      param_width_i;
    logic [raw_rgb_pkg::Y_WIDTH-1:0]      param_height_i;
    raw_rgb_pkg::raw_t                    s_tdata_i;
    logic                                 s_tuser_i;
    logic                                 s_tvalid_i;
    logic                                 s_tready_o;
    raw_rgb_pkg::pixel_t                  m_tdata_o;
    logic                                 m_tuser_o;
    logic                                 m_tlast_o;
    logic                                 m_tvalid_o;
    logic                                 m_tready_i;
    logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i;
    raw_rgb_pkg::wb_data_t                s_wb_dat_i;
    raw_rgb_pkg::wb_data_t                s_wb_dat_o;
    logic                                 s_wb_we_i;
    logic                                 s_wb_stb_i;
    logic                                 s_wb_ack_o;

    raw_rgb_pkg::raw_t         frame [FRAME_H][FRAME_W];
    raw_rgb_pkg::bayer_phase_t sh_phase;
    raw_rgb_pkg::bayer_phase_t act_phase;
    int                        sh_coeff [9];
    int                        act_coeff [9];
    int                        mix_coeff [9] = '{384, -64, 200, -256, 85, -3, 1, 700, -500};
    exp_t                      exp_q [$];
    exp_t                      head;
    integer                    seed;
    int                        cycle_count;
    int                        user_accept_cycle;
    bit                        random_ready;
    logic                      ready_next;

    video_raw_to_rgb dut (.*);

    always #50 aclk = ~aclk;

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge aclk);
        #10;
    endtask

    task automatic check_pixel(input raw_rgb_pkg::pixel_t got, input exp_t exp,
                               input logic got_last, input logic got_user);
        if (got !== exp.px) begin
            $display("ERROR m_tdata_o got %h expected %h", got, exp.px);
            abort_run();
        end else if (got_last !== exp.last) begin
            $display("ERROR m_tlast_o got %h expected %h", got_last, exp.last);
            abort_run();
        end else if (got_user !== exp.user) begin
            $display("ERROR m_tuser_o got %h expected %h", got_user, exp.user);
            abort_run();
        end
    endtask

    task automatic check_word(input raw_rgb_pkg::wb_data_t got, input raw_rgb_pkg::wb_data_t exp,
                              input logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] adr);
        if (got !== exp) begin
            $display("ERROR s_wb_dat_o at address %h got %h expected %h", adr, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got);
        if (got != raw_rgb_pkg::PIPE_LATENCY) begin
            $display("ERROR m_tvalid_o latency got %h expected %h",
                     got, raw_rgb_pkg::PIPE_LATENCY);
            abort_run();
        end
    endtask

    // one single-beat wishbone cycle where ack comes one cycle after stb
    task automatic wb_access(input logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] adr, input logic we,
                             input raw_rgb_pkg::wb_data_t wdat,
                             output raw_rgb_pkg::wb_data_t rdat);
        s_wb_adr_i = adr;
        s_wb_dat_i = wdat;
        s_wb_we_i  = we;
        s_wb_stb_i = 1'b1;
        do next_cycle(); while (s_wb_ack_o !== 1'b1);
        rdat       = s_wb_dat_o;
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
        next_cycle();
    endtask

    task automatic wb_write(input logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] adr, input int val);
        raw_rgb_pkg::wb_data_t unused;
        wb_access(adr, 1'b1, raw_rgb_pkg::wb_data_t'(val), unused);
    endtask

    task automatic wb_read_check(input logic [raw_rgb_pkg::WB_ADR_WIDTH-1:0] adr, input int val);
        raw_rgb_pkg::wb_data_t got;
        wb_access(adr, 1'b0, '0, got);
        check_word(got, raw_rgb_pkg::wb_data_t'(val), adr);
    endtask

    // window of (x-1,y-1) (x,y-1) (x-1,y) (x,y) with edges clamped to zero
    function automatic raw_rgb_pkg::pixel_t expected_pixel(input int x, input int y);
        int cx;
        int cy;
        int px;
        int py;
        int val;
        int g_sum;
        int acc;
        int color [3];
        int out [3];
        raw_rgb_pkg::pixel_t p;
        g_sum    = 0;
        color[0] = 0;
        color[2] = 0;
        for (int k = 0; k < 4; k++) begin
            cx  = x - (((k & 1) != 0) ? 0 : 1);
            cy  = y - (((k & 2) != 0) ? 0 : 1);
            val = frame[(cy < 0) ? 0 : cy][(cx < 0) ? 0 : cx];
            px  = (cx & 1) ^ int'(act_phase[0]);   // color judged before clamping
            py  = (cy & 1) ^ int'(act_phase[1]);
            if (px == 0 && py == 0) color[0] = val;
            else if (px == 1 && py == 1) color[2] = val;
            else g_sum += val;
        end
        color[1] = g_sum / 2;
        for (int row = 0; row < 3; row++) begin
            acc = 0;
            for (int col = 0; col < 3; col++) acc += act_coeff[3*row+col] * color[col];
            acc = acc >>> raw_rgb_pkg::COEFF_FRAC;   // arithmetic shift floors negative sums
            out[row] = (acc < 0) ? 0 : ((acc > PIX_MAX) ? PIX_MAX : acc);
        end
        p.raw   = frame[y][x];
        p.rgb.r = raw_rgb_pkg::raw_t'(out[0]);
        p.rgb.g = raw_rgb_pkg::raw_t'(out[1]);
        p.rgb.b = raw_rgb_pkg::raw_t'(out[2]);
        return p;
    endfunction

    task automatic fill_random_frame();
        for (int y = 0; y < FRAME_H; y++)
            for (int x = 0; x < FRAME_W; x++) frame[y][x] = raw_rgb_pkg::raw_t'($random(seed));
    endtask

    task automatic send_frame(input bit upd, input bit gaps);
        exp_t e;
        logic accepted;
        if (upd) begin
            act_phase = sh_phase;   // shadow goes live at this frame's first pixel
            act_coeff = sh_coeff;
        end
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                e.px   = expected_pixel(x, y);
                e.last = (x == FRAME_W - 1);
                e.user = (x == 0 && y == 0);
                exp_q.push_back(e);
            end
        end
        update_req_i = upd;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                while (gaps && (($random(seed) & 3) == 0)) begin
                    s_tvalid_i = 1'b0;
                    next_cycle();
                end
                s_tdata_i  = frame[y][x];
                s_tuser_i  = (x == 0 && y == 0);
                s_tvalid_i = 1'b1;
                do begin
                    @(negedge aclk);
                    accepted = s_tready_o;
                    next_cycle();
                end while (accepted !== 1'b1);
                if (x == 0 && y == 0) begin
                    user_accept_cycle = cycle_count;
                end
            end
        end
        s_tvalid_i   = 1'b0;
        s_tuser_i    = 1'b0;
        update_req_i = 1'b0;
    endtask

    // ready is picked at the falling edge and applied after the next rising edge
    always begin
        @(negedge aclk);
        ready_next = !random_ready || (($random(seed) & 3) != 0);
        next_cycle();
        m_tready_i = ready_next;
    end

    always @(negedge aclk) begin
        if (rst_n_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
                $display("an output pixel arrived when none was expected");
                abort_run();
            end else begin
                head = exp_q.pop_front();
                check_pixel(m_tdata_o, head, m_tlast_o, m_tuser_o);
                // with the sink always ready a frame's first pixel has the fixed latency
                if (head.user && !random_ready) begin
                    check_latency(cycle_count - user_accept_cycle);
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d pixels still expected",
                     cycle_count, exp_q.size());
            abort_run();
        end
    end

    initial begin
        seed              = 32'h3920_186e;
        aclk              = 1'b0;
        rst_n_i           = 1'b0;
        update_req_i      = 1'b0;
        param_width_i     = FRAME_W;
        param_height_i    = FRAME_H;
        s_tdata_i         = '0;
        s_tuser_i         = 1'b0;
        s_tvalid_i        = 1'b0;
        m_tready_i        = 1'b1;
        s_wb_adr_i        = '0;
        s_wb_dat_i        = '0;
        s_wb_we_i         = 1'b0;
        s_wb_stb_i        = 1'b0;
        random_ready      = 1'b0;
        cycle_count       = 0;
        user_accept_cycle = 0;
        sh_phase          = '0;
        act_phase         = '0;
        for (int i = 0; i < 9; i++) begin
            sh_coeff[i]  = (i % 4 == 0) ? 32'h100 : 0;   // identity matrix where one is 0x100
            act_coeff[i] = sh_coeff[i];
        end
        repeat (4) @(posedge aclk);
        #10;
        rst_n_i = 1'b1;

        wb_read_check(raw_rgb_pkg::REG_PHASE, 0);
        for (int i = 0; i < 9; i++) wb_read_check(raw_rgb_pkg::REG_COEFF_BASE + i, sh_coeff[i]);

        fill_random_frame();
        send_frame(1'b0, 1'b0);

        for (int ph = 1; ph < 4; ph++) begin
            wb_write(raw_rgb_pkg::REG_PHASE, ph);
            sh_phase = raw_rgb_pkg::bayer_phase_t'(ph);
            wb_read_check(raw_rgb_pkg::REG_PHASE, ph);
            fill_random_frame();
            send_frame(1'b0, 1'b0);   // still on the previous phase
            fill_random_frame();
            send_frame(1'b1, 1'b0);
        end

        // mixed signs, fractions and gains above one drive both clip limits
        for (int i = 0; i < 9; i++) begin
            wb_write(raw_rgb_pkg::REG_COEFF_BASE + i, mix_coeff[i]);
            sh_coeff[i] = mix_coeff[i];
            wb_read_check(raw_rgb_pkg::REG_COEFF_BASE + i, mix_coeff[i]);
        end
        fill_random_frame();
        send_frame(1'b1, 1'b0);

        random_ready = 1'b1;
        repeat (2) begin
            fill_random_frame();
            send_frame(1'b0, 1'b1);
        end

        while (exp_q.size() != 0) @(posedge aclk);
        repeat (4 * raw_rgb_pkg::PIPE_LATENCY) @(posedge aclk);
        @(negedge aclk);
        if (m_tvalid_o === 1'b0 && s_tready_o === 1'b1) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("the output still holds a pixel after the last expected one");
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

// ==== sim.f ====
verilog/raw_rgb_pkg.sv
verilog/img_if.sv
verilog/axi4s_img_bridge.sv
verilog/img_demosaic_2x2.sv
verilog/img_color_matrix.sv
verilog/img_param_regs.sv
verilog/video_raw_to_rgb.sv
verification/video_raw_to_rgb_sva.sv
verification/tb_video_raw_to_rgb.sv

// ==== Bender.yml ====
package:
  name: video_raw_to_rgb

sources:
  - verilog/raw_rgb_pkg.sv
  - verilog/img_if.sv
  - verilog/axi4s_img_bridge.sv
  - verilog/img_demosaic_2x2.sv
  - verilog/img_color_matrix.sv
  - verilog/img_param_regs.sv
  - verilog/video_raw_to_rgb.sv
  - target: test
    files:
      - verification/video_raw_to_rgb_sva.sv
      - verification/tb_video_raw_to_rgb.sv
